// ==== logic/sdp_rdma_ig_pkg.sv ====
package sdp_rdma_ig_pkg;

  // ========================================
  // address and field widths
  // ========================================

  // byte address seen by the dma
  localparam int DMA_AW = 64;
  // one atom is 16 bytes
  localparam int ATOM_SHIFT = 4;
  // address counted in atoms
  localparam int ATOM_AW = DMA_AW - ATOM_SHIFT;
  // strides and low base, in atoms
  localparam int STRIDE_W = 28;
  // upper base word
  localparam int ADDR_HI_W = ATOM_AW - STRIDE_W;
  // width, height, channel
  localparam int DIM_W = 13;
  // last surface index
  localparam int SURF_CNT_W = 10;
  // atom count minus one
  localparam int REQ_SIZE_W = 15;

  // ========================================
  // payloads and buffering
  // ========================================

  // size above a 64-bit address
  localparam int DMA_PD_W = DMA_AW + REQ_SIZE_W;
  // cube end on top of size
  localparam int CQ_PD_W = REQ_SIZE_W + 1;
  // request buffer slots, also the starting credits
  localparam int REQ_FIFO_DEPTH = 4;
  // holds 0..REQ_FIFO_DEPTH
  localparam int CREDIT_W = 3;
  localparam int STALL_W = 32;

  // ========================================
  // configuration encodings
  // ========================================

  typedef enum logic [1:0] {
    INT8  = 2'd0,
    INT16 = 2'd1,
    FP16  = 2'd2
  } proc_prec_e;

  // both operands double the bytes per element
  typedef enum logic [1:0] {
    MUL  = 2'd0,
    ALU  = 2'd1,
    BOTH = 2'd2
  } data_use_e;

  typedef enum logic {
    PER_KERNEL  = 1'b0,
    PER_ELEMENT = 1'b1
  } data_mode_e;

  typedef enum logic {
    ONE_BYTE = 1'b0,
    TWO_BYTE = 1'b1
  } data_size_e;

  // producer fsm
  typedef enum logic {
    IDLE = 1'b0,
    RUN  = 1'b1
  } seq_state_e;

endpackage

// ==== logic/rdma_cmd_seq.sv ====
`timescale 1ns/1ns
module rdma_cmd_seq (
  input  logic                                  nvdla_core_clk,
  input  logic                                  nvdla_core_rstn,
  input  logic                                  op_load,
  input  sdp_rdma_ig_pkg::proc_prec_e           proc_precision,
  input  sdp_rdma_ig_pkg::data_mode_e           data_mode,
  input  sdp_rdma_ig_pkg::data_size_e           data_size,
  input  sdp_rdma_ig_pkg::data_use_e            data_use,
  input  logic [sdp_rdma_ig_pkg::DIM_W-1:0]     channel,
  input  logic [sdp_rdma_ig_pkg::DIM_W-1:0]     height,
  input  logic [sdp_rdma_ig_pkg::DIM_W-1:0]     width,
  input  logic [sdp_rdma_ig_pkg::ADDR_HI_W-1:0] base_addr_high,
  input  logic [sdp_rdma_ig_pkg::STRIDE_W-1:0]  base_addr_low,
  input  logic [sdp_rdma_ig_pkg::STRIDE_W-1:0]  line_stride,
  input  logic [sdp_rdma_ig_pkg::STRIDE_W-1:0]  surface_stride,
  input  logic                                  credit_ret,
  output logic                                  push,
  output logic [sdp_rdma_ig_pkg::ATOM_AW-1:0]   push_addr,
  output logic [sdp_rdma_ig_pkg::REQ_SIZE_W-1:0] push_size,
  output logic                                  push_cube_end
);

  import sdp_rdma_ig_pkg::*;

  seq_state_e              state;
  logic [CREDIT_W-1:0]     credit_cnt;
  logic [SURF_CNT_W-1:0]   count_c;
  logic [DIM_W-1:0]        count_h;
  logic [SURF_CNT_W-1:0]   size_of_surf;
  logic [1:0]              elem_shift;
  logic [REQ_SIZE_W-1:0]   size_of_straight;
  logic [REQ_SIZE_W-1:0]   size_of_width;
  logic [ATOM_AW-1:0]      base_addr_line;
  logic [ATOM_AW-1:0]      base_addr_surf;
  logic                    mode_1x1_pack;
  logic                    is_last_c;
  logic                    is_surf_end;
  logic                    is_cube_end;

  // count-minus-one scaled by 2^sh, result stays count-minus-one
  function automatic logic [REQ_SIZE_W-1:0] scale_size(
    input logic [REQ_SIZE_W-1:0] cnt_m1,
    input logic [1:0]            sh
  );
    logic [REQ_SIZE_W-1:0] fill;
    fill = REQ_SIZE_W'((1 << sh) - 1);
    return (cnt_m1 << sh) | fill;
  endfunction

  // ========================================
  // cube shape
  // ========================================
  assign mode_1x1_pack = (width == '0) && (height == '0);

  // channel surfaces of 16 (int8) or 8 elements
  assign size_of_surf = (proc_precision == INT8) ? SURF_CNT_W'(channel >> 4)
                                                 : SURF_CNT_W'(channel >> 3);

  assign is_last_c   = (count_c == size_of_surf);
  // one request per line, so last line ends the surface
  assign is_surf_end = (count_h == height);
  assign is_cube_end = (data_mode == PER_KERNEL) || mode_1x1_pack ||
                       (is_surf_end && is_last_c);

  // ========================================
  // request size
  // ========================================
  // log2 of bytes per element
  always_comb begin
    if (proc_precision == INT8) begin
      if (data_use == BOTH) begin
        elem_shift = (data_size == ONE_BYTE) ? 2'd1 : 2'd2;
      end else begin
        elem_shift = (data_size == ONE_BYTE) ? 2'd0 : 2'd1;
      end
    end else begin
      // 16-bit data, element is always two bytes
      elem_shift = (data_use == BOTH) ? 2'd1 : 2'd0;
    end
  end

  assign size_of_straight = scale_size(REQ_SIZE_W'(size_of_surf), elem_shift);
  assign size_of_width    = scale_size(REQ_SIZE_W'(width), elem_shift);

  // ========================================
  // control and credits
  // ========================================
  // only offer while a buffer slot is known free
  assign push = (state == RUN) && (credit_cnt != '0);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state <= IDLE;
    end else if (op_load) begin
      state <= RUN;
    end else if (push && is_cube_end) begin
      state <= IDLE;
    end
  end

  // pop credits arrive while pushes spend them
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      credit_cnt <= CREDIT_W'(REQ_FIFO_DEPTH);
    end else begin
      credit_cnt <= credit_cnt + CREDIT_W'(credit_ret) - CREDIT_W'(push);
    end
  end

  // line and surface position
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_c <= '0;
      count_h <= '0;
    end else if (op_load) begin
      count_c <= '0;
      count_h <= '0;
    end else if (push) begin
      if (is_cube_end) begin
        count_c <= '0;
        count_h <= '0;
      end else if (is_surf_end) begin
        count_c <= count_c + 1'b1;
        count_h <= '0;
      end else begin
        count_h <= count_h + 1'b1;
      end
    end
  end

  // ========================================
  // address stepping
  // ========================================
  always_ff @(posedge nvdla_core_clk) begin
    if (op_load) begin
      base_addr_line <= {base_addr_high, base_addr_low};
      base_addr_surf <= {base_addr_high, base_addr_low};
    end else if (push) begin
      if (is_surf_end) begin
        // next surface starts a fresh line walk
        base_addr_line <= base_addr_surf + ATOM_AW'(surface_stride);
        base_addr_surf <= base_addr_surf + ATOM_AW'(surface_stride);
      end else begin
        base_addr_line <= base_addr_line + ATOM_AW'(line_stride);
      end
    end
  end

  assign push_addr     = base_addr_line;
  assign push_size     = ((data_mode == PER_KERNEL) || mode_1x1_pack) ? size_of_straight
                                                                      : size_of_width;
  assign push_cube_end = is_cube_end;

endmodule

// ==== logic/rdma_req_fifo.sv ====
`timescale 1ns/1ns
module rdma_req_fifo (
  input  logic                                   nvdla_core_clk,
  input  logic                                   nvdla_core_rstn,
  input  logic                                   push,
  input  logic [sdp_rdma_ig_pkg::ATOM_AW-1:0]    push_addr,
  input  logic [sdp_rdma_ig_pkg::REQ_SIZE_W-1:0] push_size,
  input  logic                                   push_cube_end,
  input  logic                                   pop,
  output logic                                   head_vld,
  output logic [sdp_rdma_ig_pkg::ATOM_AW-1:0]    head_addr,
  output logic [sdp_rdma_ig_pkg::REQ_SIZE_W-1:0] head_size,
  output logic                                   head_cube_end,
  output logic                                   credit_ret
);

  import sdp_rdma_ig_pkg::*;

  localparam int PTR_W = $clog2(REQ_FIFO_DEPTH);

  // extra msb tells full from empty
  logic [PTR_W:0]          wr_ptr;
  logic [PTR_W:0]          rd_ptr;
  logic [ATOM_AW-1:0]      addr_mem [REQ_FIFO_DEPTH];
  logic [REQ_SIZE_W-1:0]   size_mem [REQ_FIFO_DEPTH];
  logic                    end_mem  [REQ_FIFO_DEPTH];

  // ========================================
  // storage
  // ========================================
  // producer holds credits, so a push always has room
  always_ff @(posedge nvdla_core_clk) begin
    if (push) begin
      addr_mem[wr_ptr[PTR_W-1:0]] <= push_addr;
      size_mem[wr_ptr[PTR_W-1:0]] <= push_size;
      end_mem[wr_ptr[PTR_W-1:0]]  <= push_cube_end;
    end
  end

  // ========================================
  // pointers
  // ========================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_ptr <= '0;
    end else if (push) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      rd_ptr <= '0;
    end else if (pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // one credit back per freed slot, a cycle late
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      credit_ret <= 1'b0;
    end else begin
      credit_ret <= pop;
    end
  end

  // fall-through head
  assign head_vld      = (wr_ptr != rd_ptr);
  assign head_addr     = addr_mem[rd_ptr[PTR_W-1:0]];
  assign head_size     = size_mem[rd_ptr[PTR_W-1:0]];
  assign head_cube_end = end_mem[rd_ptr[PTR_W-1:0]];

endmodule

// ==== logic/rdma_req_dispatch.sv ====
`timescale 1ns/1ns
module rdma_req_dispatch (
  input  logic                                   nvdla_core_clk,
  input  logic                                   nvdla_core_rstn,
  input  logic                                   head_vld,
  input  logic [sdp_rdma_ig_pkg::ATOM_AW-1:0]    head_addr,
  input  logic [sdp_rdma_ig_pkg::REQ_SIZE_W-1:0] head_size,
  input  logic                                   head_cube_end,
  input  logic                                   dma_rd_req_rdy,
  input  logic                                   ig2cq_prdy,
  input  logic                                   op_load,
  input  logic                                   op_en,
  input  logic                                   perf_dma_en,
  output logic                                   pop,
  output logic                                   dma_rd_req_vld,
  output logic [sdp_rdma_ig_pkg::DMA_PD_W-1:0]   dma_rd_req_pd,
  output logic                                   ig2cq_pvld,
  output logic [sdp_rdma_ig_pkg::CQ_PD_W-1:0]    ig2cq_pd,
  output logic [sdp_rdma_ig_pkg::STALL_W-1:0]    dp2reg_rdma_stall
);

  import sdp_rdma_ig_pkg::*;

  logic                 xfer;
  logic                 stall_cen;
  logic                 stall_inc;
  logic [STALL_W-1:0]   stall_cnt;

  // ========================================
  // joint handshake
  // ========================================
  // each sink only sees valid once the other is ready
  assign dma_rd_req_vld = head_vld & ig2cq_prdy;
  assign ig2cq_pvld     = head_vld & dma_rd_req_rdy;

  // dma and queue take the entry together
  assign xfer = head_vld & dma_rd_req_rdy & ig2cq_prdy;
  assign pop  = xfer;

  // ========================================
  // payload packing
  // ========================================
  // size on top, byte address below
  assign dma_rd_req_pd = {head_size, head_addr, {ATOM_SHIFT{1'b0}}};

  // cube end flag above size
  assign ig2cq_pd = {head_cube_end, head_size};

  // ========================================
  // stall counter
  // ========================================
  assign stall_cen = op_en & perf_dma_en;
  // offered but dma not taking it
  assign stall_inc = dma_rd_req_vld & ~dma_rd_req_rdy;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stall_cnt <= '0;
    end else if (stall_cen) begin
      if (op_load) begin
        // new layer restarts the count
        stall_cnt <= '0;
      end else if (stall_inc) begin
        stall_cnt <= stall_cnt + 1'b1;
      end
    end
  end

  assign dp2reg_rdma_stall = stall_cnt;

endmodule

// ==== logic/sdp_rdma_ig.sv ====
`timescale 1ns/1ns
module sdp_rdma_ig (
  input  logic                                   nvdla_core_clk,
  input  logic                                   nvdla_core_rstn,
  input  logic                                   op_load,
  input  logic                                   op_en,
  input  logic                                   perf_dma_en,
  input  sdp_rdma_ig_pkg::proc_prec_e            proc_precision,
  input  sdp_rdma_ig_pkg::data_mode_e            data_mode,
  input  sdp_rdma_ig_pkg::data_size_e            data_size,
  input  sdp_rdma_ig_pkg::data_use_e             data_use,
  input  logic [sdp_rdma_ig_pkg::DIM_W-1:0]      channel,
  input  logic [sdp_rdma_ig_pkg::DIM_W-1:0]      height,
  input  logic [sdp_rdma_ig_pkg::DIM_W-1:0]      width,
  input  logic [sdp_rdma_ig_pkg::ADDR_HI_W-1:0]  base_addr_high,
  input  logic [sdp_rdma_ig_pkg::STRIDE_W-1:0]   base_addr_low,
  input  logic [sdp_rdma_ig_pkg::STRIDE_W-1:0]   line_stride,
  input  logic [sdp_rdma_ig_pkg::STRIDE_W-1:0]   surface_stride,
  output logic [sdp_rdma_ig_pkg::DMA_PD_W-1:0]   dma_rd_req_pd,
  output logic                                   dma_rd_req_vld,
  input  logic                                   dma_rd_req_rdy,
  output logic [sdp_rdma_ig_pkg::CQ_PD_W-1:0]    ig2cq_pd,
  output logic                                   ig2cq_pvld,
  input  logic                                   ig2cq_prdy,
  output logic [sdp_rdma_ig_pkg::STALL_W-1:0]    dp2reg_rdma_stall
);

  import sdp_rdma_ig_pkg::*;

  // producer to buffer
  logic                  push;
  logic [ATOM_AW-1:0]    push_addr;
  logic [REQ_SIZE_W-1:0] push_size;
  logic                  push_cube_end;
  logic                  credit_ret;
  // buffer to consumer
  logic                  head_vld;
  logic [ATOM_AW-1:0]    head_addr;
  logic [REQ_SIZE_W-1:0] head_size;
  logic                  head_cube_end;
  logic                  pop;

  // ========================================
  // cube walk, request buffer, dispatch
  // ========================================
  rdma_cmd_seq cmd_seq_i (.*);

  rdma_req_fifo req_fifo_i (.*);

  rdma_req_dispatch req_dispatch_i (.*);

endmodule

// ==== verification/sdp_rdma_ig_clkgen.sv ====
`timescale 1ns/1ns
module sdp_rdma_ig_clkgen (
  output logic nvdla_core_clk,
  output logic nvdla_core_rstn
);

  // 20 ns period
  initial begin
    nvdla_core_clk = 1'b0;
    forever #10 nvdla_core_clk = ~nvdla_core_clk;
  end

  // low for two rising edges, released off the edge
  initial begin
    nvdla_core_rstn = 1'b0;
    repeat (2) @(posedge nvdla_core_clk);
    #2;
    nvdla_core_rstn = 1'b1;
  end

endmodule

// ==== verification/sdp_rdma_ig_tb.sv ====
`timescale 1ns/1ns
module sdp_rdma_ig_tb;

  import sdp_rdma_ig_pkg::*;

  // cycles allowed per awaited event
  localparam int WAIT_LIMIT = 60;

  logic nvdla_core_clk, nvdla_core_rstn;
  logic op_load, op_en, perf_dma_en;
  proc_prec_e proc_precision;
  data_mode_e data_mode;
  data_size_e data_size;
  data_use_e data_use;
  logic [DIM_W-1:0] channel, height, width;
  logic [ADDR_HI_W-1:0] base_addr_high;
  logic [STRIDE_W-1:0] base_addr_low, line_stride, surface_stride;
  logic [DMA_PD_W-1:0] dma_rd_req_pd;
  logic dma_rd_req_vld, dma_rd_req_rdy;
  logic [CQ_PD_W-1:0] ig2cq_pd;
  logic ig2cq_pvld, ig2cq_prdy;
  logic [STALL_W-1:0] dp2reg_rdma_stall;

  // expected payloads, oldest first
  logic [DMA_PD_W-1:0] exp_dma_q[$];
  logic [CQ_PD_W-1:0] exp_cq_q[$];
  integer seed = 32'h5ce6;
  int err_cnt = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;

  sdp_rdma_ig_clkgen clkgen_i (.*);
  sdp_rdma_ig dut_i (.*);

  // ========================================
  // compare tasks
  // ========================================
  task automatic compare_dma_pd(input string name, input logic [DMA_PD_W-1:0] exp,
                                input logic [DMA_PD_W-1:0] act);
    if (exp !== act) begin
      $display("ERROR at %0t: %s expected addr %h size %h, got addr %h size %h", $time, name,
               exp[DMA_AW-1:0], exp[DMA_PD_W-1:DMA_AW], act[DMA_AW-1:0], act[DMA_PD_W-1:DMA_AW]);
      err_cnt++;
    end
  endtask

  task automatic compare_cq_pd(input string name, input logic [CQ_PD_W-1:0] exp,
                               input logic [CQ_PD_W-1:0] act);
    if (exp !== act) begin
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic compare_stall(input string name, input logic [STALL_W-1:0] exp,
                               input logic [STALL_W-1:0] act);
    if (exp !== act) begin
      $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t: %s did not happen within %0d cycles", $time, what, WAIT_LIMIT);
    err_cnt++;
  endtask

  // ========================================
  // reference model
  // ========================================
  // two-byte int8 and both operands each double the atoms per element
  function automatic int unsigned size_factor(input proc_prec_e prec, input data_size_e dsize,
                                              input data_use_e use_sel);
    int unsigned fac;
    fac = ((prec == INT8) && (dsize == TWO_BYTE)) ? 2 : 1;
    if (use_sel == BOTH) fac = fac * 2;
    return fac;
  endfunction

  task automatic add_expected(input logic [ATOM_AW-1:0] addr, input logic [REQ_SIZE_W-1:0] size,
                              input logic cube_end);
    exp_dma_q.push_back({size, DMA_AW'(addr) << ATOM_SHIFT});
    exp_cq_q.push_back({cube_end, size});
  endtask

  task automatic build_expected();
    logic [ATOM_AW-1:0] base, addr;
    logic [REQ_SIZE_W-1:0] size;
    int unsigned fac, last_c, c, h;
    exp_dma_q.delete();
    exp_cq_q.delete();
    fac = size_factor(proc_precision, data_size, data_use);
    // 16 channels per int8 surface, 8 otherwise
    last_c = (proc_precision == INT8) ? channel / 16 : channel / 8;
    base = {base_addr_high, base_addr_low};
    if ((data_mode == PER_KERNEL) || ((width == 0) && (height == 0))) begin
      size = REQ_SIZE_W'((last_c + 1) * fac - 1);
      add_expected(base, size, 1'b1);
    end else begin
      size = REQ_SIZE_W'((width + 1) * fac - 1);
      for (c = 0; c <= last_c; c++) begin
        for (h = 0; h <= height; h++) begin
          addr = base + ATOM_AW'(c) * ATOM_AW'(surface_stride) +
                 ATOM_AW'(h) * ATOM_AW'(line_stride);
          add_expected(addr, size, (c == last_c) && (h == height));
        end
      end
    end
  endtask

  // ========================================
  // drivers
  // ========================================
  task automatic set_config(input proc_prec_e prec, input data_mode_e mode,
                            input data_size_e dsize, input data_use_e use_sel,
                            input logic [DIM_W-1:0] ch, input logic [DIM_W-1:0] h,
                            input logic [DIM_W-1:0] w, input logic [ATOM_AW-1:0] base,
                            input logic [STRIDE_W-1:0] ls, input logic [STRIDE_W-1:0] ss);
    @(posedge nvdla_core_clk);
    #2;
    proc_precision = prec;
    data_mode = mode;
    data_size = dsize;
    data_use = use_sel;
    channel = ch;
    height = h;
    width = w;
    base_addr_high = base[ATOM_AW-1:STRIDE_W];
    base_addr_low = base[STRIDE_W-1:0];
    line_stride = ls;
    surface_stride = ss;
  endtask

  task automatic pulse_load();
    @(posedge nvdla_core_clk);
    #2 op_load = 1'b1;
    @(posedge nvdla_core_clk);
    #2 op_load = 1'b0;
  endtask

  // accept every expected request at the falling edge
  task automatic collect_requests(input bit random_bp);
    int idle_cnt;
    bit dma_acc, cq_acc;
    idle_cnt = 0;
    while ((exp_dma_q.size() > 0) && (idle_cnt < WAIT_LIMIT)) begin
      @(posedge nvdla_core_clk);
      #2;
      dma_rd_req_rdy = random_bp ? (($random(seed) & 3) != 0) : 1'b1;
      ig2cq_prdy = random_bp ? (($random(seed) & 3) != 0) : 1'b1;
      @(negedge nvdla_core_clk);
      dma_acc = dma_rd_req_vld && dma_rd_req_rdy;
      cq_acc = ig2cq_pvld && ig2cq_prdy;
      if (dma_acc != cq_acc) begin
        $display("dma and queue acceptance differ at time %0t", $time);
        err_cnt++;
      end
      if (dma_acc) begin
        compare_dma_pd("dma_rd_req_pd", exp_dma_q.pop_front(), dma_rd_req_pd);
        compare_cq_pd("ig2cq_pd", exp_cq_q.pop_front(), ig2cq_pd);
        idle_cnt = 0;
      end else begin
        idle_cnt++;
      end
    end
    if (exp_dma_q.size() > 0) report_timeout("next request");
    @(posedge nvdla_core_clk);
    #2;
    dma_rd_req_rdy = 1'b1;
    ig2cq_prdy = 1'b1;
  endtask

  // nothing may follow the cube-end request
  task automatic check_no_extra();
    int n;
    for (n = 0; n < 8; n++) begin
      @(negedge nvdla_core_clk);
      if (dma_rd_req_vld || ig2cq_pvld) begin
        $display("unexpected extra request offered at time %0t", $time);
        err_cnt++;
      end
    end
  endtask

  task automatic run_cube(input bit random_bp);
    build_expected();
    pulse_load();
    collect_requests(random_bp);
    check_no_extra();
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: FAILED with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // ========================================
  // directed tests
  // ========================================
  task automatic test_reset();
    int errs, n;
    errs = err_cnt;
    n = 0;
    while ((nvdla_core_rstn !== 1'b1) && (n < WAIT_LIMIT)) begin
      @(posedge nvdla_core_clk);
      n++;
    end
    if (nvdla_core_rstn !== 1'b1) report_timeout("reset release");
    @(negedge nvdla_core_clk);
    if (dma_rd_req_vld || ig2cq_pvld) begin
      $display("a valid is high right after reset at time %0t", $time);
      err_cnt++;
    end
    compare_stall("dp2reg_rdma_stall", '0, dp2reg_rdma_stall);
    end_test("reset", errs);
  endtask

  task automatic test_per_kernel();
    int errs;
    errs = err_cnt;
    set_config(INT8, PER_KERNEL, ONE_BYTE, MUL, 13'd32, 13'd1, 13'd3, 60'h100, 28'h10, 28'h80);
    run_cube(1'b0);
    set_config(INT8, PER_KERNEL, TWO_BYTE, BOTH, 13'd48, 13'd2, 13'd4, 60'hab_0000_0200, 28'h20,
               28'h200);
    run_cube(1'b0);
    set_config(INT16, PER_KERNEL, TWO_BYTE, BOTH, 13'd40, 13'd1, 13'd1, 60'h7_f000_0040, 28'h8,
               28'h40);
    run_cube(1'b0);
    end_test("per_kernel", errs);
  endtask

  task automatic test_element_walk();
    int errs;
    errs = err_cnt;
    // three surfaces of three lines
    set_config(INT8, PER_ELEMENT, ONE_BYTE, MUL, 13'd40, 13'd2, 13'd5, 60'h1234_5678, 28'h40,
               28'h400);
    run_cube(1'b0);
    end_test("element_walk", errs);
  endtask

  task automatic test_pack_1x1();
    int errs;
    errs = err_cnt;
    set_config(INT16, PER_ELEMENT, TWO_BYTE, BOTH, 13'd20, 13'd0, 13'd0, 60'h3000, 28'h10, 28'h100);
    run_cube(1'b0);
    end_test("pack_1x1", errs);
  endtask

  task automatic test_backpressure();
    int errs;
    errs = err_cnt;
    set_config(FP16, PER_ELEMENT, TWO_BYTE, BOTH, 13'd17, 13'd3, 13'd7, 60'hf_0000_1000, 28'h10,
               28'h100);
    run_cube(1'b1);
    end_test("backpressure", errs);
  endtask

  task automatic test_stall();
    int errs, n, held;
    logic [STALL_W-1:0] stall_seen;
    errs = err_cnt;
    set_config(INT8, PER_KERNEL, ONE_BYTE, MUL, 13'd32, 13'd0, 13'd2, 60'h500, 28'h10, 28'h80);
    op_en = 1'b1;
    perf_dma_en = 1'b1;
    dma_rd_req_rdy = 1'b0;
    ig2cq_prdy = 1'b1;
    build_expected();
    pulse_load();
    // count offered-but-refused cycles while the dma holds off
    stall_seen = '0;
    held = 0;
    n = 0;
    while ((held < 6) && (n < WAIT_LIMIT)) begin
      @(negedge nvdla_core_clk);
      if (dma_rd_req_vld && !dma_rd_req_rdy) begin
        stall_seen++;
        held++;
      end
      n++;
    end
    if (held < 6) report_timeout("stalled dma offer");
    collect_requests(1'b0);
    compare_stall("dp2reg_rdma_stall", stall_seen, dp2reg_rdma_stall);
    // next layer load restarts the count
    build_expected();
    pulse_load();
    @(negedge nvdla_core_clk);
    compare_stall("dp2reg_rdma_stall", '0, dp2reg_rdma_stall);
    collect_requests(1'b0);
    check_no_extra();
    end_test("stall_count", errs);
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    op_load = 1'b0;
    op_en = 1'b0;
    perf_dma_en = 1'b0;
    proc_precision = INT8;
    data_mode = PER_KERNEL;
    data_size = ONE_BYTE;
    data_use = MUL;
    channel = '0;
    height = '0;
    width = '0;
    base_addr_high = '0;
    base_addr_low = '0;
    line_stride = '0;
    surface_stride = '0;
    dma_rd_req_rdy = 1'b1;
    ig2cq_prdy = 1'b1;
    test_reset();
    test_per_kernel();
    test_element_walk();
    test_pack_1x1();
    test_backpressure();
    test_stall();
    $display("summary: %0d tests ok, %0d tests failed", pass_cnt, fail_cnt);
    if ((fail_cnt == 0) && (err_cnt == 0)) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== sdp_rdma_ig.f ====
logic/sdp_rdma_ig_pkg.sv
logic/rdma_cmd_seq.sv
logic/rdma_req_fifo.sv
logic/rdma_req_dispatch.sv
logic/sdp_rdma_ig.sv
verification/sdp_rdma_ig_clkgen.sv
verification/sdp_rdma_ig_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the sdp_rdma_ig testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  --top-module sdp_rdma_ig_tb \
  -f sdp_rdma_ig.f \
  -o sdp_rdma_ig_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sdp_rdma_ig_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "All tests passed" <<< "$sim_out"; then
  exit 0
fi
exit 1
